//--- aes_ahb_top.f
+incdir+hdl
hdl/crypto_pkg.sv
hdl/ahb_pkg.sv
hdl/aes_ifs.sv
hdl/ahb_slave_write.sv
hdl/crypto_reg_block.sv
hdl/block_fifo.sv
hdl/aes_ahb_top.sv
dv/tb_aes_ahb_top.sv

//--- dv/tb_aes_ahb_top.sv
// Directed testbench for the AES-CTR AHB write slave: register writes, errors and FIFO stall
`include "aes_ahb_cfg.svh"

module tb_aes_ahb_top
  import ahb_pkg::*;
  import crypto_pkg::*;
();

  timeunit 1ns;
  timeprecision 10ps;

  // Summed test length is well under two hundred cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic                    tb_HCLK = 1'b0;
  logic                    arst_n;
  logic                    hsel;
  logic [`AHB_DATA_W-1:0]  haddr;
  htrans_t                 htrans;
  hburst_t                 hburst;
  logic                    hready;
  logic [`AHB_DATA_W-1:0]  hwdata;
  logic                    hready_out;
  logic                    write_error;
  block_t                  key;
  block_t                  nonce;
  logic                    blk_valid;
  logic                    blk_pop;
  block_t                  blk_text;
  logic [`AHB_DATA_W-1:0]  blk_dest;
  int                      cycle_count = 0;

  always #2 tb_HCLK = ~tb_HCLK;

  // Single slave on the bus, so the ready seen by it is its own
  assign hready = hready_out;

  aes_ahb_top aes_ahb_top_inst (
    .tb_HCLK     (tb_HCLK),
    .arst_n      (arst_n),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hburst      (hburst),
    .hready      (hready),
    .hwdata      (hwdata),
    .hready_out  (hready_out),
    .write_error (write_error),
    .key         (key),
    .nonce       (nonce),
    .blk_valid   (blk_valid),
    .blk_pop     (blk_pop),
    .blk_text    (blk_text),
    .blk_dest    (blk_dest)
  );

  always @(posedge tb_HCLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Simulation ran for %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "Timeout reached");
    end
  end

  task automatic check_eq(input string name, input logic [127:0] actual,
                          input logic [127:0] expected);
    if (actual !== expected)
    begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // Inputs change 1 ns after the rising edge, outputs are read at the same point
  task automatic step();
    @(posedge tb_HCLK);
    #1;
  endtask

  // Pipelined write burst: address of beat i overlaps the data phase of beat i-1
  task automatic ahb_write(input logic [31:0] base, input int n, input htrans_t first_trans,
                           input hburst_t burst, input logic [31:0] data [$], input logic ok);
    logic [31:0] addr;
    for (int i = 0; i <= n; i++)
    begin
      hsel   = (i < n);
      haddr  = (i < n) ? base + 32'(4 * i) : '0;
      htrans = (i == n) ? IDLE : ((i == 0) ? first_trans : SEQ);
      hburst = burst;
      if (i > 0)
      begin
        hwdata = data[i-1];
        check_eq("write_error", write_error, !ok);
      end
      while (!hready_out)
        step();
      step();
      addr = base + 32'(4 * (i - 1));
      if ((i > 0) && ok && (addr < `ADDR_NONCE))
        check_eq("key word", key[addr[3:2]*`AHB_DATA_W +: `AHB_DATA_W], data[i-1]);
      else if ((i > 0) && ok && (addr < `ADDR_DEST))
        check_eq("nonce word", nonce[addr[3:2]*`AHB_DATA_W +: `AHB_DATA_W], data[i-1]);
    end
    // Error flag lasts one data phase only
    check_eq("write_error", write_error, 1'b0);
  endtask

  function automatic block_t rand_block();
    block_t b;
    for (int k = 0; k < `BLOCK_WORDS; k++)
      b[k*`AHB_DATA_W +: `AHB_DATA_W] = $urandom();
    return b;
  endfunction

  task automatic write_words(input logic [31:0] base, input block_t b);
    logic [31:0] q [$];
    for (int k = 0; k < `BLOCK_WORDS; k++)
      q.push_back(b[k*`AHB_DATA_W +: `AHB_DATA_W]);
    ahb_write(base, `BLOCK_WORDS, NONSEQ, INCR, q, 1'b1);
  endtask

  task automatic write_single(input logic [31:0] addr, input htrans_t trans,
                              input hburst_t burst, input logic ok);
    logic [31:0] q [$];
    q.push_back($urandom());
    ahb_write(addr, 1, trans, burst, q, ok);
  endtask

  task automatic pop_block(input block_t exp_text, input logic [31:0] exp_dest);
    check_eq("blk_valid", blk_valid, 1'b1);
    check_eq("blk_text", blk_text, exp_text);
    check_eq("blk_dest", blk_dest, exp_dest);
    blk_pop = 1'b1;
    step();
    blk_pop = 1'b0;
  endtask

  task automatic test_reset();
    check_eq("key", key, '0);
    check_eq("nonce", nonce, '0);
    check_eq("blk_text", blk_text, '0);
    check_eq("blk_dest", blk_dest, '0);
    check_eq("write_error", write_error, 1'b0);
    check_eq("blk_valid", blk_valid, 1'b0);
    check_eq("hready_out", hready_out, 1'b1);
  endtask

  task automatic test_key_nonce();
    block_t k;
    block_t n;
    k = rand_block();
    n = rand_block();
    write_words(`ADDR_KEY, k);
    check_eq("key", key, k);
    write_words(`ADDR_NONCE, n);
    check_eq("nonce", nonce, n);
  endtask

  task automatic test_block();
    block_t       t;
    logic [31:0]  d;
    logic [31:0]  q [$];
    t = rand_block();
    d = $urandom();
    q = {d};
    ahb_write(`ADDR_DEST, 1, NONSEQ, SINGLE, q, 1'b1);
    check_eq("blk_valid", blk_valid, 1'b0);
    write_words(`ADDR_TEXT, t);
    pop_block(t, d);
    check_eq("blk_valid", blk_valid, 1'b0);
  endtask

  task automatic test_errors();
    block_t k;
    block_t n;
    k = key;
    n = nonce;
    write_single(`ADDR_KEY, BUSY, SINGLE, 1'b0);
    write_single(`ADDR_LAST + 32'h4, NONSEQ, SINGLE, 1'b0);
    write_single(`ADDR_KEY + 32'h2, NONSEQ, SINGLE, 1'b0);
    write_single(`ADDR_NONCE, NONSEQ, WRAP4, 1'b0);
    check_eq("key", key, k);
    check_eq("nonce", nonce, n);
    check_eq("blk_valid", blk_valid, 1'b0);
  endtask

  task automatic test_backpressure();
    block_t       texts [`BLOCK_FIFO_DEPTH+1];
    logic [31:0]  dests [`BLOCK_FIFO_DEPTH+1];
    logic [31:0]  q [$];
    for (int b = 0; b <= `BLOCK_FIFO_DEPTH; b++)
    begin
      texts[b] = rand_block();
      dests[b] = $urandom();
      q = {dests[b]};
      ahb_write(`ADDR_DEST, 1, NONSEQ, SINGLE, q, 1'b1);
      if (b < `BLOCK_FIFO_DEPTH)
        write_words(`ADDR_TEXT, texts[b]);
    end
    fork
      write_words(`ADDR_TEXT, texts[`BLOCK_FIFO_DEPTH]);
      begin
        while (hready_out)
          step();
        repeat (3) step();
        check_eq("hready_out", hready_out, 1'b0);
        pop_block(texts[0], dests[0]);
      end
    join
    for (int b = 1; b <= `BLOCK_FIFO_DEPTH; b++)
      pop_block(texts[b], dests[b]);
    check_eq("blk_valid", blk_valid, 1'b0);
  endtask

  initial
  begin
    void'($urandom(32'h3994_0598));
    arst_n  = 1'b0;
    hsel    = 1'b0;
    haddr   = '0;
    htrans  = IDLE;
    hburst  = SINGLE;
    hwdata  = '0;
    blk_pop = 1'b0;
    repeat (5) @(posedge tb_HCLK);
    #1;
    arst_n = 1'b1;
    test_reset();
    test_key_nonce();
    test_block();
    test_errors();
    test_backpressure();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- hdl/aes_ahb_cfg.svh
// AES-CTR AHB write slave configuration: bus width, block size, FIFO depth, register map
`ifndef AES_AHB_CFG_SVH
`define AES_AHB_CFG_SVH

// Bus and register word width
`define AHB_DATA_W 32

// Words per key, nonce or plain-text block
`define BLOCK_WORDS 4

// Block FIFO entries, power of two
`define BLOCK_FIFO_DEPTH 4

// Byte offsets of the register map
`define ADDR_KEY 32'h0000_0000
`define ADDR_NONCE 32'h0000_0010
`define ADDR_DEST 32'h0000_0020
`define ADDR_TEXT 32'h0000_0024
`define ADDR_LAST 32'h0000_0030

`endif

//--- hdl/aes_ahb_top.sv
// AES-CTR accelerator write side: AHB slave, crypto registers and block FIFO
`include "aes_ahb_cfg.svh"

module aes_ahb_top
  import ahb_pkg::*;
  import crypto_pkg::*;
(
  input  logic                    tb_HCLK,
  input  logic                    arst_n,
  input  logic                    hsel,
  input  logic [`AHB_DATA_W-1:0]  haddr,
  input  htrans_t                 htrans,
  input  hburst_t                 hburst,
  input  logic                    hready,
  input  logic [`AHB_DATA_W-1:0]  hwdata,
  output logic                    hready_out,
  output logic                    write_error,
  output block_t                  key,
  output block_t                  nonce,
  output logic                    blk_valid,
  input  logic                    blk_pop,
  output block_t                  blk_text,
  output logic [`AHB_DATA_W-1:0]  blk_dest
);

  reg_write_if   reg_wr ();
  block_push_if  push_if ();

  ahb_slave_write ahb_slave_write_inst (
    .tb_HCLK     (tb_HCLK),
    .arst_n      (arst_n),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hburst      (hburst),
    .hready      (hready),
    .hwdata      (hwdata),
    .hready_out  (hready_out),
    .write_error (write_error),
    .reg_wr      (reg_wr.master),
    .fifo_full   (push_if.full)
  );

  crypto_reg_block crypto_reg_block_inst (
    .tb_HCLK   (tb_HCLK),
    .arst_n    (arst_n),
    .reg_wr    (reg_wr.slave),
    .push_port (push_if.src),
    .key       (key),
    .nonce     (nonce)
  );

  block_fifo block_fifo_inst (
    .tb_HCLK   (tb_HCLK),
    .arst_n    (arst_n),
    .push_port (push_if.dst),
    .blk_valid (blk_valid),
    .blk_pop   (blk_pop),
    .blk_text  (blk_text),
    .blk_dest  (blk_dest)
  );

endmodule

//--- hdl/aes_ifs.sv
// Internal links of the AES write slave: register write strobe and block push
`include "aes_ahb_cfg.svh"

interface reg_write_if
  import crypto_pkg::*;
();

  logic                    wr_en;
  reg_field_t              field;
  word_idx_t               word_idx;
  logic [`AHB_DATA_W-1:0]  wdata;

  modport master (
    output wr_en,
    output field,
    output word_idx,
    output wdata
  );

  modport slave (
    input wr_en,
    input field,
    input word_idx,
    input wdata
  );

endinterface

interface block_push_if
  import crypto_pkg::*;
();

  logic         push;
  fifo_entry_t  entry;
  logic         full;

  // Producer must keep push low while full is high
  modport src (
    output push,
    output entry,
    input  full
  );

  modport dst (
    input  push,
    input  entry,
    output full
  );

endinterface

//--- hdl/ahb_pkg.sv
// AHB-Lite encodings and the captured address phase of the write slave
package ahb_pkg;
  import crypto_pkg::*;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // Address phase as seen by the data phase that follows it
  typedef struct packed {
    logic        valid;
    reg_field_t  field;
    word_idx_t   word_idx;
    logic        err;
  } addr_phase_t;

endpackage

//--- hdl/ahb_slave_write.sv
// AHB-Lite write slave: tracks address and data phases, decodes the map, flags errors, stalls
`include "aes_ahb_cfg.svh"

module ahb_slave_write
  import ahb_pkg::*;
  import crypto_pkg::*;
(
  input  logic                    tb_HCLK,
  input  logic                    arst_n,
  input  logic                    hsel,
  input  logic [`AHB_DATA_W-1:0]  haddr,
  input  htrans_t                 htrans,
  input  hburst_t                 hburst,
  input  logic                    hready,
  input  logic [`AHB_DATA_W-1:0]  hwdata,
  output logic                    hready_out,
  output logic                    write_error,
  reg_write_if.master             reg_wr,
  input  logic                    fifo_full
);

  addr_phase_t  aphase;
  addr_phase_t  dphase;
  logic         last_text;
  logic         stall;
  logic         wr_en;

  // Map a byte offset onto a register field and word, flagging illegal transfers
  function automatic addr_phase_t decode(
    input logic [`AHB_DATA_W-1:0] addr,
    input htrans_t                trans,
    input hburst_t                burst
  );
    addr_phase_t               ph;
    logic [`AHB_DATA_W-1:0]    rel;
    ph.valid = 1'b1;
    if (addr < `ADDR_NONCE)
    begin
      ph.field = FIELD_KEY;
      rel = addr - `ADDR_KEY;
    end
    else if (addr < `ADDR_DEST)
    begin
      ph.field = FIELD_NONCE;
      rel = addr - `ADDR_NONCE;
    end
    else if (addr < `ADDR_TEXT)
    begin
      ph.field = FIELD_DEST;
      rel = addr - `ADDR_DEST;
    end
    else
    begin
      ph.field = FIELD_TEXT;
      rel = addr - `ADDR_TEXT;
    end
    ph.word_idx = rel[WORD_IDX_W+1:2];
    ph.err = (trans == BUSY) || (addr > `ADDR_LAST) || (addr[1:0] != 2'b00) ||
             (burst inside {WRAP4, WRAP8, WRAP16});
    return ph;
  endfunction

  // Only a selected, ready, non-idle transfer opens a data phase
  always_comb
  begin
    if (hsel && hready && (htrans != IDLE))
      aphase = decode(haddr, htrans, hburst);
    else
      aphase = '0;
  end

  // The data phase is held for as long as this slave stalls
  always_ff @(posedge tb_HCLK or negedge arst_n)
  begin
    if (!arst_n)
      dphase <= '0;
    else if (hready_out)
      dphase <= aphase;
  end

  // Final text word completes a block, which needs a free FIFO entry
  assign last_text = dphase.valid && !dphase.err &&
                     (dphase.field == FIELD_TEXT) && (dphase.word_idx == LAST_WORD);
  assign stall = last_text && fifo_full;

  assign hready_out  = !stall;
  assign write_error = dphase.valid && dphase.err;
  assign wr_en       = dphase.valid && !dphase.err && !stall;

  assign reg_wr.wr_en    = wr_en;
  assign reg_wr.field    = dphase.field;
  assign reg_wr.word_idx = dphase.word_idx;
  assign reg_wr.wdata    = hwdata;

  // A flagged data phase never reaches the registers
  a_no_write_on_error: assert property (
    @(posedge tb_HCLK) disable iff (!arst_n)
    write_error |-> !wr_en
  );

  // Stall only on the final text word, and the stalled phase is kept
  a_stall_holds_phase: assert property (
    @(posedge tb_HCLK) disable iff (!arst_n)
    !hready_out |-> last_text ##1 $stable(dphase)
  );

endmodule

//--- hdl/block_fifo.sv
// Circular FIFO of plain-text blocks and their destinations for the cipher core
`include "aes_ahb_cfg.svh"

module block_fifo
  import crypto_pkg::*;
(
  input  logic                    tb_HCLK,
  input  logic                    arst_n,
  block_push_if.dst               push_port,
  output logic                    blk_valid,
  input  logic                    blk_pop,
  output block_t                  blk_text,
  output logic [`AHB_DATA_W-1:0]  blk_dest
);

  localparam int DEPTH = `BLOCK_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  fifo_entry_t       mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              do_push;
  logic              do_pop;
  fifo_entry_t       head;

  assign push_port.full = (count == (PTR_W+1)'(DEPTH));
  assign blk_valid      = (count != '0);

  assign do_push = push_port.push && !push_port.full;
  assign do_pop  = blk_pop && blk_valid;

  // Entry storage
  always_ff @(posedge tb_HCLK)
  begin
    if (do_push)
      mem[wr_ptr] <= push_port.entry;
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge tb_HCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // Empty FIFO shows zeros instead of stale entries
  assign head     = blk_valid ? mem[rd_ptr] : '0;
  assign blk_text = head.text;
  assign blk_dest = head.dest;

  a_no_pop_when_empty: assert property (
    @(posedge tb_HCLK) disable iff (!arst_n)
    blk_pop |-> blk_valid
  );

endmodule

//--- hdl/crypto_pkg.sv
// Crypto register types: register fields, 128-bit blocks and block FIFO entries
`include "aes_ahb_cfg.svh"

package crypto_pkg;

  // Word select inside a key, nonce or text block
  localparam int WORD_IDX_W = $clog2(`BLOCK_WORDS);
  typedef logic [WORD_IDX_W-1:0] word_idx_t;
  localparam word_idx_t LAST_WORD = word_idx_t'(`BLOCK_WORDS - 1);

  // Register targeted by a write
  typedef enum logic [1:0] {
    FIELD_KEY,
    FIELD_NONCE,
    FIELD_DEST,
    FIELD_TEXT
  } reg_field_t;

  // Word 0 sits in the low bits
  typedef logic [`BLOCK_WORDS*`AHB_DATA_W-1:0] block_t;

  typedef struct packed {
    block_t                  text;
    logic [`AHB_DATA_W-1:0]  dest;
  } fifo_entry_t;

endpackage

//--- hdl/crypto_reg_block.sv
// Key, nonce, destination and plain-text registers; a completed text block is pushed out
`include "aes_ahb_cfg.svh"

module crypto_reg_block
  import crypto_pkg::*;
(
  input  logic         tb_HCLK,
  input  logic         arst_n,
  reg_write_if.slave   reg_wr,
  block_push_if.src    push_port,
  output block_t       key,
  output block_t       nonce
);

  logic [`AHB_DATA_W-1:0]  dest;
  block_t                  text;
  block_t                  text_next;
  logic                    text_wr;

  assign text_wr = reg_wr.wr_en && (reg_wr.field == FIELD_TEXT);

  // Text block with the incoming word merged in
  always_comb
  begin
    text_next = text;
    text_next[reg_wr.word_idx*`AHB_DATA_W +: `AHB_DATA_W] = reg_wr.wdata;
  end

  always_ff @(posedge tb_HCLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key   <= '0;
      nonce <= '0;
      dest  <= '0;
      text  <= '0;
    end
    else if (reg_wr.wr_en)
    begin
      case (reg_wr.field)
        FIELD_KEY:
          key[reg_wr.word_idx*`AHB_DATA_W +: `AHB_DATA_W] <= reg_wr.wdata;
        FIELD_NONCE:
          nonce[reg_wr.word_idx*`AHB_DATA_W +: `AHB_DATA_W] <= reg_wr.wdata;
        FIELD_DEST:
          dest <= reg_wr.wdata;
        default:
          text <= text_next;
      endcase
    end
  end

  // Last word arrives straight from the bus so the block is whole this cycle
  assign push_port.push       = text_wr && (reg_wr.word_idx == LAST_WORD);
  assign push_port.entry.text = text_next;
  assign push_port.entry.dest = dest;

  // Slave stall must keep the push back while the FIFO is full
  a_no_push_when_full: assert property (
    @(posedge tb_HCLK) disable iff (!arst_n)
    push_port.push |-> !push_port.full
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the AES AHB write slave simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f aes_ahb_top.f --top-module tb_aes_ahb_top \
  -Mdir obj_dir -o tb_aes_ahb_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_aes_ahb_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi
